/* Bender.yml */
package:
  name: tile_buffer

sources:
  - files:
      - logic/tbuf_pkg.sv
      - logic/ram_bank_512x64.sv
      - logic/ram_dp_w64_b8_d2880.sv
      - logic/byte_packer.sv
      - logic/axil_tbuf_regs.sv
      - logic/tile_buffer_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_tile_buffer.sv

/* bench/tb_axil_tasks.svh */
// axi4-lite master tasks
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// single-beat write, bready held low for hold cycles once bvalid is up
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          input logic [3:0] strb, input int hold, output logic [1:0] bresp);
        @(negedge rd_clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        while (axil_rsp.bvalid)
                @(negedge rd_clk);      // accepted on the next edge
        @(negedge rd_clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid)
                @(negedge rd_clk);
        repeat (hold) @(negedge rd_clk);
        bresp = axil_rsp.bresp;
        axil_req.bready = 1'b1;
        @(negedge rd_clk);
        axil_req.bready = 1'b0;
endtask

// single-beat read, rready held low for hold cycles once rvalid is up
task automatic axil_read(input axil_addr_t addr, input int hold,
                         output axil_data_t data, output logic [1:0] rresp);
        @(negedge rd_clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        while (!axil_rsp.arready)
                @(negedge rd_clk);
        @(negedge rd_clk);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid)
                @(negedge rd_clk);
        repeat (hold) @(negedge rd_clk);
        data  = axil_rsp.rdata;
        rresp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        @(negedge rd_clk);
        axil_req.rready = 1'b0;
endtask

`endif

/* bench/tb_tile_buffer.sv */
// tile buffer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tile_buffer;
        import tbuf_pkg::*;

        localparam int CLK_PERIOD  = 40;
        localparam int N_BYTES     = 64 + 8*510 + 64 + 3 + 8*(DEPTH_WORDS-1) + 10;
        localparam int N_AXI       = 80;
        localparam int CYCLE_LIMIT = 40*(N_BYTES + N_AXI) + 2000;

        logic       rd_clk;
        logic       rst_n;
        byte_t      s_data;
        logic       s_valid;
        logic       s_ready;
        axil_req_t  axil_req;
        axil_rsp_t  axil_rsp;

        word_t      mdl_mem [DEPTH_WORDS];  // reference memory
        int         mdl_fill;
        int         mdl_lanes;
        word_t      mdl_word;
        int         seed = 87;
        int         cycles = 0;
        int         mismatches = 0;
        int         assert_fails = 0;
        axil_data_t rdata;
        logic [1:0] resp;

        tile_buffer_top i_dut (
                .rd_clk_i   (rd_clk),
                .rst_n_i    (rst_n),
                .s_data_i   (s_data),
                .s_valid_i  (s_valid),
                .s_ready_o  (s_ready),
                .axil_req_i (axil_req),
                .axil_rsp_o (axil_rsp)
        );

        `include "tb_axil_tasks.svh"

        initial begin
                rd_clk = 1'b0;
                forever #(CLK_PERIOD/2) rd_clk = ~rd_clk;
        end

        always @(posedge rd_clk) begin
                cycles <= cycles + 1;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
                        $display("STATUS: FAIL");
                        $finish;
                end
        end

        a_full_stall: assert property (@(posedge rd_clk) disable iff (!rst_n)
                (i_dut.fill == fill_t'(DEPTH_WORDS)) |-> !s_ready)
                else begin
                        assert_fails++;
                        $display("s_ready_o was high while the buffer was full");
                end

        a_rd_latency: assert property (@(posedge rd_clk) disable iff (!rst_n)
                axil_req.arvalid && axil_rsp.arready
                |=> !axil_rsp.rvalid ##1 !axil_rsp.rvalid ##1 axil_rsp.rvalid)
                else begin
                        assert_fails++;
                        $display("rvalid did not rise two cycles after the read address");
                end

        a_r_stable: assert property (@(posedge rd_clk) disable iff (!rst_n)
                axil_rsp.rvalid && !axil_req.rready
                |=> axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
                else begin
                        assert_fails++;
                        $display("read response changed while rready was low");
                end

        a_ar_blocked: assert property (@(posedge rd_clk) disable iff (!rst_n)
                axil_rsp.rvalid |-> !axil_rsp.arready)
                else begin
                        assert_fails++;
                        $display("arready was high with a read response pending");
                end

        a_b_hold: assert property (@(posedge rd_clk) disable iff (!rst_n)
                axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
                else begin
                        assert_fails++;
                        $display("bvalid dropped while bready was low");
                end

        // address and data taken together, response one cycle later
        a_aw_accept: assert property (@(posedge rd_clk) disable iff (!rst_n)
                axil_req.awvalid && axil_req.wvalid && !axil_rsp.bvalid
                |-> axil_rsp.awready && axil_rsp.wready
                    ##1 axil_rsp.bvalid && !axil_rsp.awready && !axil_rsp.wready)
                else begin
                        assert_fails++;
                        $display("write address and data were not accepted as one pulse");
                end

        task automatic check_equal(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
                assert (got === exp)
                else begin
                        mismatches++;
                        $display("Mismatch %s exp %h got %h", name, exp, got);
                end
        endtask

        // one byte into the stream, model follows the accepted byte
        task automatic push_byte(input byte_t b, input int gap);
                s_valid = 1'b0;
                repeat (gap) @(negedge rd_clk);
                s_data  = b;
                s_valid = 1'b1;
                while (!s_ready)
                        @(negedge rd_clk);
                @(negedge rd_clk);
                s_valid = 1'b0;
                mdl_word[8*mdl_lanes +: 8] = b;
                mdl_lanes++;
                if (mdl_lanes == 8) begin
                        mdl_mem[mdl_fill] = mdl_word;
                        mdl_fill++;
                        mdl_lanes = 0;
                end
        endtask

        task automatic push_random(input int count, input int max_gap);
                int gap;
                for (int i = 0; i < count; i++) begin
                        gap = (max_gap > 0) ? ({$random(seed)} % (max_gap + 1)) : 0;
                        push_byte(byte_t'($random(seed)), gap);
                end
        endtask

        task automatic ctrl_write(input axil_data_t data, input int hold);
                axil_write(ADDR_CTRL, data, 4'h1, hold, resp);
                check_equal("bresp", 64'(RESP_OKAY), 64'(resp));
                if (data[1]) begin
                        mdl_fill  = 0;
                        mdl_lanes = 0;
                end else if (data[0] && mdl_lanes > 0) begin
                        for (int k = 0; k < mdl_lanes; k++)
                                mdl_mem[mdl_fill][8*k +: 8] = mdl_word[8*k +: 8];
                        mdl_fill++;
                        mdl_lanes = 0;  // held lanes only, the rest keep old data
                end
        endtask

        task automatic check_status();
                axil_read(ADDR_STATUS, 0, rdata, resp);
                check_equal("status.fill", 64'(mdl_fill), 64'(rdata[11:0]));
                check_equal("status.partial", 64'(mdl_lanes != 0), 64'(rdata[16]));
                check_equal("rresp", 64'(RESP_OKAY), 64'(resp));
        endtask

        task automatic check_word(input int idx, input int hold);
                for (int h = 0; h < 2; h++) begin
                        axil_read(axil_addr_t'(idx*8 + h*4), hold, rdata, resp);
                        check_equal($sformatf("rdata[word %0d half %0d]", idx, h),
                                    64'(mdl_mem[idx][32*h +: 32]), 64'(rdata));
                        check_equal("rresp", 64'(RESP_OKAY), 64'(resp));
                end
        endtask

        initial begin
                rst_n     = 1'b0;
                s_data    = '0;
                s_valid   = 1'b0;
                axil_req  = '0;
                mdl_fill  = 0;
                mdl_lanes = 0;
                mdl_word  = '0;
                repeat (5) @(negedge rd_clk);
                rst_n = 1'b1;

                // full words, fill steps once per eight bytes
                for (int w = 0; w < 8; w++) begin
                        push_random(8, 3);
                        check_status();
                end
                for (int w = 0; w < 8; w++)
                        check_word(w, 0);

                // clear and refill across the bank 0/1 boundary
                ctrl_write(32'h2, 0);
                push_random(8*510, 0);
                push_random(64, 3);
                check_status();
                for (int w = 510; w < 518; w++)
                        check_word(w, 0);

                // three new lanes over old word 0, then flush
                ctrl_write(32'h2, 0);
                push_random(3, 1);
                check_status();
                ctrl_write(32'h1, 0);
                check_status();
                check_word(0, 0);

                // fill to the end, stream must stall
                push_random(8*(DEPTH_WORDS-1), 0);
                check_status();
                s_data  = 8'hA5;
                s_valid = 1'b1;
                repeat (10) @(negedge rd_clk);
                s_valid = 1'b0;
                check_word(DEPTH_WORDS-1, 0);

                // stalled response channels; flush with nothing held
                check_word(1024, 4);
                ctrl_write(32'h1, 3);
                check_status();

                axil_read(16'h5A00, 0, rdata, resp);
                check_equal("rresp", 64'(RESP_SLVERR), 64'(resp));
                check_equal("rdata", 64'h0, 64'(rdata));
                axil_read(16'h9000, 2, rdata, resp);
                check_equal("rresp", 64'(RESP_SLVERR), 64'(resp));
                check_equal("rdata", 64'h0, 64'(rdata));
                axil_write(16'h0000, 32'hDEADBEEF, 4'hF, 0, resp);
                check_equal("bresp", 64'(RESP_SLVERR), 64'(resp));
                check_word(0, 0);
                ctrl_write(32'h3, 0);   // both bits, clear wins
                check_status();

                $display("checks done: %0d mismatches, %0d assertion failures",
                         mismatches, assert_fails);
                if (mismatches == 0 && assert_fails == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

/* logic/axil_tbuf_regs.sv */
// axi4-lite register and data window port
`timescale 1ns/1ps
`default_nettype none

module axil_tbuf_regs (
        input  wire                       rd_clk_i,
        input  wire                       rst_n_i,
        input  wire tbuf_pkg::axil_req_t  axil_req_i,
        output tbuf_pkg::axil_rsp_t       axil_rsp_o,
        input  wire tbuf_pkg::fill_t      fill_i,
        input  wire                       partial_i,
        output logic                      flush_o,
        output logic                      clear_o,
        output tbuf_pkg::ram_rd_t         rd_o,
        input  wire tbuf_pkg::word_t      rd_data_i
);
        import tbuf_pkg::*;

        // write channel
        logic       aw_hs;
        logic       ctrl_hit;
        logic       bvalid_q;
        logic [1:0] bresp_q;
        logic       flush_q;
        logic       clear_q;

        // read channel
        rd_state_t  state_q;
        logic       ar_hs;
        axil_addr_t ar_addr_q;
        logic       win_hit;
        logic       stat_hit;
        logic       rvalid_q;
        axil_data_t rdata_q;
        logic [1:0] rresp_q;
        axil_data_t rd_word;
        logic [1:0] rd_resp;

        assign aw_hs    = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
        assign ctrl_hit = (axil_req_i.awaddr == ADDR_CTRL);

        always_ff @(posedge rd_clk_i) begin
                if (!rst_n_i) begin
                        bvalid_q <= 1'b0;
                        flush_q  <= 1'b0;
                        clear_q  <= 1'b0;
                end else begin
                        flush_q <= 1'b0;
                        clear_q <= 1'b0;
                        if (aw_hs) begin
                                bvalid_q <= 1'b1;
                                if (ctrl_hit && axil_req_i.wstrb[0]) begin
                                        clear_q <= axil_req_i.wdata[1];    // clear wins
                                        flush_q <= axil_req_i.wdata[0] && !axil_req_i.wdata[1];
                                end
                        end else if (axil_req_i.bready) begin
                                bvalid_q <= 1'b0;
                        end
                end
        end

        always_ff @(posedge rd_clk_i) begin
                if (aw_hs)
                        bresp_q <= ctrl_hit ? RESP_OKAY : RESP_SLVERR;
        end

        assign ar_hs = axil_req_i.arvalid && (state_q == RD_IDLE);

        // idle -> ram read -> capture, then hold until rready
        always_ff @(posedge rd_clk_i) begin
                if (!rst_n_i) begin
                        state_q  <= RD_IDLE;
                        rvalid_q <= 1'b0;
                end else begin
                        case (state_q)
                        RD_IDLE: begin
                                if (ar_hs)
                                        state_q <= RD_MEM;
                        end
                        RD_MEM: begin
                                state_q <= RD_RESP;
                        end
                        RD_RESP: begin
                                if (!rvalid_q) begin
                                        rvalid_q <= 1'b1;
                                end else if (axil_req_i.rready) begin
                                        rvalid_q <= 1'b0;
                                        state_q  <= RD_IDLE;
                                end
                        end
                        default: state_q <= RD_IDLE;
                        endcase
                end
        end

        assign win_hit  = (ar_addr_q < DATA_WINDOW_END);
        assign stat_hit = (ar_addr_q == ADDR_STATUS);

        assign rd_o = '{en: (state_q == RD_MEM) && win_hit, addr: ar_addr_q[14:3]};

        always_comb begin
                rd_word = '0;
                rd_resp = RESP_SLVERR;
                if (win_hit) begin
                        rd_word = ar_addr_q[2] ? rd_data_i[63:32] : rd_data_i[31:0];
                        rd_resp = RESP_OKAY;
                end else if (stat_hit) begin
                        rd_word = {15'd0, partial_i, 4'd0, fill_i};
                        rd_resp = RESP_OKAY;
                end
        end

        always_ff @(posedge rd_clk_i) begin
                if (ar_hs)
                        ar_addr_q <= axil_req_i.araddr;
                if ((state_q == RD_RESP) && !rvalid_q) begin
                        rdata_q <= rd_word;
                        rresp_q <= rd_resp;
                end
        end

        always_comb begin
                axil_rsp_o.awready = aw_hs;
                axil_rsp_o.wready  = aw_hs;
                axil_rsp_o.bvalid  = bvalid_q;
                axil_rsp_o.bresp   = bresp_q;
                axil_rsp_o.arready = (state_q == RD_IDLE);
                axil_rsp_o.rvalid  = rvalid_q;
                axil_rsp_o.rdata   = rdata_q;
                axil_rsp_o.rresp   = rresp_q;
        end

        assign flush_o = flush_q;
        assign clear_o = clear_q;

endmodule

`default_nettype wire

/* logic/byte_packer.sv */
// byte stream to 64-bit word packer
`timescale 1ns/1ps
`default_nettype none

module byte_packer (
        input  wire                    rd_clk_i,
        input  wire                    rst_n_i,
        input  wire tbuf_pkg::byte_t   s_data_i,
        input  wire                    s_valid_i,
        output logic                   s_ready_o,
        input  wire                    flush_i,
        input  wire                    clear_i,
        output tbuf_pkg::ram_wr_t      wr_o,
        output tbuf_pkg::fill_t        fill_o,
        output logic                   partial_o
);
        import tbuf_pkg::*;

        logic       ready_q;
        logic [2:0] lane_q;             // next lane to fill
        ben_t       lanes_q;            // lanes held, not yet written
        fill_t      fill_q;
        word_t      word_q;
        word_t      word_nxt;

        logic       wr_en_q;
        word_addr_t wr_addr_q;
        ben_t       wr_ben_q;
        word_t      wr_data_q;

        logic       full;
        logic       acc;
        logic       last;
        logic       do_flush;

        // a completed word still in flight counts toward full
        assign full = (fill_q == fill_t'(DEPTH_WORDS)) ||
                      (wr_en_q && (fill_q == fill_t'(DEPTH_WORDS - 1)));

        assign s_ready_o = ready_q && !flush_i && !clear_i && !full;
        assign acc       = s_valid_i && s_ready_o;
        assign last      = acc && (lane_q == 3'd7);
        assign do_flush  = flush_i && !clear_i && (|lanes_q);

        always_comb begin
                word_nxt = word_q;
                if (acc)
                        word_nxt[8*lane_q +: 8] = s_data_i;
        end

        always_ff @(posedge rd_clk_i) begin
                if (!rst_n_i) begin
                        ready_q <= 1'b0;
                        lane_q  <= '0;
                        lanes_q <= '0;
                        fill_q  <= '0;
                        wr_en_q <= 1'b0;
                end else begin
                        ready_q <= 1'b1;
                        wr_en_q <= last || do_flush;
                        if (wr_en_q)
                                fill_q <= fill_q + fill_t'(1);     // counts on the write edge

                        if (clear_i) begin
                                lane_q  <= '0;
                                lanes_q <= '0;
                                fill_q  <= '0;
                        end else if (flush_i) begin
                                lane_q  <= '0;
                                lanes_q <= '0;
                        end else if (acc) begin
                                lane_q <= lane_q + 3'd1;            // wraps after lane 7
                                if (last)
                                        lanes_q <= '0;
                                else
                                        lanes_q[lane_q] <= 1'b1;
                        end
                end
        end

        always_ff @(posedge rd_clk_i) begin
                word_q <= word_nxt;
                if (last || do_flush) begin
                        wr_addr_q <= word_addr_t'(fill_q);
                        wr_ben_q  <= last ? '1 : lanes_q;
                        wr_data_q <= word_nxt;
                end
        end

        assign wr_o = '{en: wr_en_q, addr: wr_addr_q, ben: wr_ben_q, data: wr_data_q};

        assign fill_o    = fill_q;
        assign partial_o = |lanes_q;

endmodule

`default_nettype wire

/* logic/ram_bank_512x64.sv */
// single 512x64 ram bank
`timescale 1ns/1ps
`default_nettype none

module ram_bank_512x64 (
        input  wire             rd_clk_i,
        input  wire tbuf_pkg::ram_wr_t wr_i,
        input  wire tbuf_pkg::ram_rd_t rd_i,
        output tbuf_pkg::word_t rd_data_o
);
        import tbuf_pkg::*;

        word_t mem [BANK_DEPTH];

        // byte-lane writes, low 9 address bits only
        always_ff @(posedge rd_clk_i) begin
                if (wr_i.en) begin
                        for (int k = 0; k < $bits(ben_t); k++) begin
                                if (wr_i.ben[k])
                                        mem[wr_i.addr[8:0]][8*k +: 8] <= wr_i.data[8*k +: 8];
                        end
                end
        end

        // registered read, old data on a same-word collision
        always_ff @(posedge rd_clk_i) begin
                if (rd_i.en)
                        rd_data_o <= mem[rd_i.addr[8:0]];
        end

endmodule

`default_nettype wire

/* logic/ram_dp_w64_b8_d2880.sv */
// 2880x64 banked dual-port ram
`timescale 1ns/1ps
`default_nettype none

module ram_dp_w64_b8_d2880 (
        input  wire             rd_clk_i,
        input  wire tbuf_pkg::ram_wr_t wr_i,
        input  wire tbuf_pkg::ram_rd_t rd_i,
        output tbuf_pkg::word_t rd_data_o
);
        import tbuf_pkg::*;

        ram_wr_t              bank_wr   [NUM_BANKS];
        ram_rd_t              bank_rd   [NUM_BANKS];
        word_t                bank_data [NUM_BANKS];
        logic [NUM_BANKS-1:0] rd_sel_q;         // bank of the last read

        for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
                assign bank_wr[i] = '{
                        en:   wr_i.en && (wr_i.addr[11:9] == 3'(i)),
                        addr: wr_i.addr,
                        ben:  wr_i.ben,
                        data: wr_i.data
                };

                assign bank_rd[i] = '{
                        en:   rd_i.en && (rd_i.addr[11:9] == 3'(i)),
                        addr: rd_i.addr
                };

                // follows the bank's output register
                always_ff @(posedge rd_clk_i) begin
                        if (rd_i.en)
                                rd_sel_q[i] <= (rd_i.addr[11:9] == 3'(i));
                end

                ram_bank_512x64 i_bank (
                        .rd_clk_i  (rd_clk_i),
                        .wr_i      (bank_wr[i]),
                        .rd_i      (bank_rd[i]),
                        .rd_data_o (bank_data[i])
                );
        end

        // banks 6 and 7 match no select bit and read as zero
        always_comb begin
                rd_data_o = '0;
                for (int i = 0; i < NUM_BANKS; i++) begin
                        rd_data_o = rd_data_o | ({$bits(word_t){rd_sel_q[i]}} & bank_data[i]);
                end
        end

endmodule

`default_nettype wire

/* logic/tbuf_pkg.sv */
// tile buffer shared types
`default_nettype none

package tbuf_pkg;

        typedef logic [7:0]  byte_t;        // one stream byte
        typedef logic [63:0] word_t;        // one stored word
        typedef logic [7:0]  ben_t;         // bit k covers byte lane k
        typedef logic [11:0] word_addr_t;   // bits 11..9 pick the bank
        typedef logic [11:0] fill_t;        // completed words, up to 2880
        typedef logic [15:0] axil_addr_t;
        typedef logic [31:0] axil_data_t;

        // memory geometry
        localparam int unsigned DEPTH_WORDS = 2880;
        localparam int unsigned BANK_DEPTH  = 512;
        localparam int unsigned NUM_BANKS   = 6;

        // register map
        localparam axil_addr_t ADDR_STATUS     = 16'h8000;
        localparam axil_addr_t ADDR_CTRL       = 16'h8004;
        localparam axil_addr_t DATA_WINDOW_END = 16'h5A00;    // 2880 words x 8 bytes

        localparam logic [1:0] RESP_OKAY   = 2'b00;
        localparam logic [1:0] RESP_SLVERR = 2'b10;

        typedef struct packed {
                logic       en;
                word_addr_t addr;
                ben_t       ben;
                word_t      data;
        } ram_wr_t;

        typedef struct packed {
                logic       en;
                word_addr_t addr;
        } ram_rd_t;

        typedef struct packed {
                axil_addr_t awaddr;
                logic       awvalid;
                axil_data_t wdata;
                logic [3:0] wstrb;
                logic       wvalid;
                logic       bready;
                axil_addr_t araddr;
                logic       arvalid;
                logic       rready;
        } axil_req_t;

        typedef struct packed {
                logic       awready;
                logic       wready;
                logic       bvalid;
                logic [1:0] bresp;
                logic       arready;
                logic       rvalid;
                axil_data_t rdata;
                logic [1:0] rresp;
        } axil_rsp_t;

        typedef enum logic [1:0] {
                RD_IDLE,
                RD_MEM,
                RD_RESP
        } rd_state_t;

endpackage

`default_nettype wire

/* logic/tile_buffer_top.sv */
// tile buffer top level
`timescale 1ns/1ps
`default_nettype none

module tile_buffer_top (
        input  wire                       rd_clk_i,
        input  wire                       rst_n_i,
        input  wire tbuf_pkg::byte_t      s_data_i,
        input  wire                       s_valid_i,
        output logic                      s_ready_o,
        input  wire tbuf_pkg::axil_req_t  axil_req_i,
        output tbuf_pkg::axil_rsp_t       axil_rsp_o
);
        import tbuf_pkg::*;

        logic    flush;
        logic    clear;
        fill_t   fill;
        logic    partial;
        ram_wr_t ram_wr;
        ram_rd_t ram_rd;
        word_t   ram_rd_data;

        byte_packer i_packer (
                .rd_clk_i  (rd_clk_i),
                .rst_n_i   (rst_n_i),
                .s_data_i  (s_data_i),
                .s_valid_i (s_valid_i),
                .s_ready_o (s_ready_o),
                .flush_i   (flush),
                .clear_i   (clear),
                .wr_o      (ram_wr),
                .fill_o    (fill),
                .partial_o (partial)
        );

        ram_dp_w64_b8_d2880 i_ram (
                .rd_clk_i  (rd_clk_i),
                .wr_i      (ram_wr),
                .rd_i      (ram_rd),
                .rd_data_o (ram_rd_data)
        );

        axil_tbuf_regs i_regs (
                .rd_clk_i   (rd_clk_i),
                .rst_n_i    (rst_n_i),
                .axil_req_i (axil_req_i),
                .axil_rsp_o (axil_rsp_o),
                .fill_i     (fill),
                .partial_i  (partial),
                .flush_o    (flush),
                .clear_o    (clear),
                .rd_o       (ram_rd),
                .rd_data_i  (ram_rd_data)
        );

endmodule

`default_nettype wire

/* tile_buffer_top.f */
+incdir+bench
logic/tbuf_pkg.sv
logic/ram_bank_512x64.sv
logic/ram_dp_w64_b8_d2880.sv
logic/byte_packer.sv
logic/axil_tbuf_regs.sv
logic/tile_buffer_top.sv
bench/tb_tile_buffer.sv
